// File: id_stage.f
logic/la32_id_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_resolve.sv
logic/id_ex_reg.sv
logic/id_stage.sv
testbench/tb_clock_gen.sv
testbench/id_stage_sva.sv
testbench/id_stage_tb.sv

// File: logic/branch_resolve.sv
module branch_resolve (
  input  la32_id_pkg::alu_op_t br_kind_i,
  input  la32_id_pkg::word_t   pc_i,
  input  la32_id_pkg::inst_t   inst_i,
  input  la32_id_pkg::word_t   op1_i,
  input  la32_id_pkg::word_t   op2_i,
  output logic                 taken_o,
  output la32_id_pkg::word_t   target_o,
  output la32_id_pkg::word_t   link_o
);

  la32_id_pkg::word_t offs16;
  la32_id_pkg::word_t offs26;
  la32_id_pkg::word_t pc_next;
  logic               signed_lt;
  logic               unsigned_lt;
  logic               cond_hit;

  assign offs16      = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
  assign offs26      = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};
  assign pc_next     = pc_i + la32_id_pkg::INST_BYTES;
  assign signed_lt   = $signed(op1_i) < $signed(op2_i);
  assign unsigned_lt = op1_i < op2_i;

  always_comb
  begin
    taken_o  = 1'b0;
    target_o = '0;
    link_o   = '0;
    cond_hit = 1'b0;
    case (br_kind_i)
      la32_id_pkg::ALU_B:
      begin
        taken_o  = 1'b1;
        target_o = pc_i + offs26;
      end
      la32_id_pkg::ALU_BL:
      begin
        taken_o  = 1'b1;
        target_o = pc_i + offs26;
        link_o   = pc_next;
      end
      la32_id_pkg::ALU_JIRL:
      begin
        // Base is the forwarded rj
        taken_o  = 1'b1;
        target_o = op1_i + offs16;
        link_o   = pc_next;
      end
      la32_id_pkg::ALU_BEQ:  cond_hit = (op1_i == op2_i);
      la32_id_pkg::ALU_BNE:  cond_hit = (op1_i != op2_i);
      la32_id_pkg::ALU_BLT:  cond_hit = signed_lt;
      la32_id_pkg::ALU_BGE:  cond_hit = !signed_lt;
      la32_id_pkg::ALU_BLTU: cond_hit = unsigned_lt;
      la32_id_pkg::ALU_BGEU: cond_hit = !unsigned_lt;
      default:               cond_hit = 1'b0;
    endcase
    if (cond_hit)
    begin
      taken_o  = 1'b1;
      target_o = pc_i + offs16;
    end
  end

endmodule

// File: logic/id_ex_reg.sv
module id_ex_reg (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   stall_i,
  input  logic                   valid_i,
  input  la32_id_pkg::alu_op_t   aluop_i,
  input  la32_id_pkg::alu_sel_t  alusel_i,
  input  la32_id_pkg::word_t     reg1_i,
  input  la32_id_pkg::word_t     reg2_i,
  input  la32_id_pkg::reg_addr_t waddr_i,
  input  logic                   wreg_i,
  input  la32_id_pkg::word_t     link_i,
  output logic                   valid_o,
  output la32_id_pkg::alu_op_t   aluop_o,
  output la32_id_pkg::alu_sel_t  alusel_o,
  output la32_id_pkg::word_t     reg1_o,
  output la32_id_pkg::word_t     reg2_o,
  output la32_id_pkg::reg_addr_t waddr_o,
  output logic                   wreg_o,
  output la32_id_pkg::word_t     link_o
);

  // Control fields clear to a bubble on reset
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_o  <= 1'b0;
      aluop_o  <= la32_id_pkg::ALU_NOP;
      alusel_o <= la32_id_pkg::SEL_NOP;
      wreg_o   <= 1'b0;
    end
    else if (!stall_i)
    begin
      valid_o  <= valid_i;
      aluop_o  <= aluop_i;
      alusel_o <= alusel_i;
      wreg_o   <= wreg_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall_i)
    begin
      reg1_o  <= reg1_i;
      reg2_o  <= reg2_i;
      waddr_o <= waddr_i;
      link_o  <= link_i;
    end
  end

endmodule

// File: logic/id_stage.sv
module id_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   id_valid_i,
  input  logic                   stall_i,
  input  la32_id_pkg::word_t     pc_i,
  input  la32_id_pkg::inst_t     inst_i,
  input  la32_id_pkg::word_t     reg1_data_i,
  input  la32_id_pkg::word_t     reg2_data_i,
  input  logic                   ex_wreg_i,
  input  la32_id_pkg::reg_addr_t ex_waddr_i,
  input  la32_id_pkg::word_t     ex_wdata_i,
  input  logic                   mem_wreg_i,
  input  la32_id_pkg::reg_addr_t mem_waddr_i,
  input  la32_id_pkg::word_t     mem_wdata_i,
  output logic                   reg1_read_o,
  output la32_id_pkg::reg_addr_t reg1_addr_o,
  output logic                   reg2_read_o,
  output la32_id_pkg::reg_addr_t reg2_addr_o,
  output logic                   branch_flag_o,
  output la32_id_pkg::word_t     branch_target_o,
  output la32_id_pkg::word_t     link_addr_o,
  output logic                   ex_valid_o,
  output la32_id_pkg::alu_op_t   ex_aluop_o,
  output la32_id_pkg::alu_sel_t  ex_alusel_o,
  output la32_id_pkg::word_t     ex_reg1_o,
  output la32_id_pkg::word_t     ex_reg2_o,
  output la32_id_pkg::reg_addr_t ex_waddr_o,
  output logic                   ex_wreg_o,
  output la32_id_pkg::word_t     ex_link_addr_o
);

  la32_id_pkg::word_t     imm;
  la32_id_pkg::word_t     operand1;
  la32_id_pkg::word_t     operand2;
  la32_id_pkg::reg_addr_t waddr;
  logic                   wreg;
  la32_id_pkg::alu_op_t   aluop;
  la32_id_pkg::alu_sel_t  alusel;
  la32_id_pkg::alu_op_t   br_kind;
  logic                   inst_ok;

  inst_decoder u_decoder (
    .inst_i     (inst_i),
    .valid_i    (id_valid_i),
    .rd1_en_o   (reg1_read_o),
    .rd2_en_o   (reg2_read_o),
    .rd1_addr_o (reg1_addr_o),
    .rd2_addr_o (reg2_addr_o),
    .waddr_o    (waddr),
    .wreg_o     (wreg),
    .imm_o      (imm),
    .aluop_o    (aluop),
    .alusel_o   (alusel),
    .br_kind_o  (br_kind),
    .inst_ok_o  (inst_ok)
  );

  operand_forward u_fwd1 (
    .rd_en_i     (reg1_read_o),
    .rd_addr_i   (reg1_addr_o),
    .rf_data_i   (reg1_data_i),
    .imm_i       (imm),
    .ex_wreg_i   (ex_wreg_i),
    .ex_waddr_i  (ex_waddr_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .operand_o   (operand1)
  );

  operand_forward u_fwd2 (
    .rd_en_i     (reg2_read_o),
    .rd_addr_i   (reg2_addr_o),
    .rf_data_i   (reg2_data_i),
    .imm_i       (imm),
    .ex_wreg_i   (ex_wreg_i),
    .ex_waddr_i  (ex_waddr_i),
    .ex_wdata_i  (ex_wdata_i),
    .mem_wreg_i  (mem_wreg_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .operand_o   (operand2)
  );

  branch_resolve u_branch (
    .br_kind_i (br_kind),
    .pc_i      (pc_i),
    .inst_i    (inst_i),
    .op1_i     (operand1),
    .op2_i     (operand2),
    .taken_o   (branch_flag_o),
    .target_o  (branch_target_o),
    .link_o    (link_addr_o)
  );

  id_ex_reg u_id_ex (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .stall_i  (stall_i),
    .valid_i  (inst_ok),
    .aluop_i  (aluop),
    .alusel_i (alusel),
    .reg1_i   (operand1),
    .reg2_i   (operand2),
    .waddr_i  (waddr),
    .wreg_i   (wreg),
    .link_i   (link_addr_o),
    .valid_o  (ex_valid_o),
    .aluop_o  (ex_aluop_o),
    .alusel_o (ex_alusel_o),
    .reg1_o   (ex_reg1_o),
    .reg2_o   (ex_reg2_o),
    .waddr_o  (ex_waddr_o),
    .wreg_o   (ex_wreg_o),
    .link_o   (ex_link_addr_o)
  );

endmodule

// File: logic/inst_decoder.sv
module inst_decoder (
  input  la32_id_pkg::inst_t     inst_i,
  input  logic                   valid_i,
  output logic                   rd1_en_o,
  output logic                   rd2_en_o,
  output la32_id_pkg::reg_addr_t rd1_addr_o,
  output la32_id_pkg::reg_addr_t rd2_addr_o,
  output la32_id_pkg::reg_addr_t waddr_o,
  output logic                   wreg_o,
  output la32_id_pkg::word_t     imm_o,
  output la32_id_pkg::alu_op_t   aluop_o,
  output la32_id_pkg::alu_sel_t  alusel_o,
  output la32_id_pkg::alu_op_t   br_kind_o,
  output logic                   inst_ok_o
);

  la32_id_pkg::reg_addr_t rd;
  la32_id_pkg::reg_addr_t rj;
  la32_id_pkg::reg_addr_t rk;
  la32_id_pkg::word_t     si12_sext;
  la32_id_pkg::word_t     ui12_zext;
  la32_id_pkg::word_t     ui5_zext;
  la32_id_pkg::word_t     offs16_sext;
  la32_id_pkg::word_t     ui20_hi;
  la32_id_pkg::alu_op_t   op;
  logic [5:0]             sub6;
  logic [4:0]             sub5;
  logic                   reg_reg;

  assign rd          = inst_i[4:0];
  assign rj          = inst_i[9:5];
  assign rk          = inst_i[14:10];
  assign sub6        = inst_i[25:20];
  assign sub5        = inst_i[19:15];
  assign si12_sext   = {{20{inst_i[21]}}, inst_i[21:10]};
  assign ui12_zext   = {20'h0, inst_i[21:10]};
  assign ui5_zext    = {27'h0, inst_i[14:10]};
  assign offs16_sext = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
  assign ui20_hi     = {inst_i[24:5], 12'h0};

  // Opcode to ALU op and immediate
  always_comb
  begin
    op      = la32_id_pkg::ALU_NOP;
    imm_o   = '0;
    reg_reg = 1'b0;
    if (valid_i && inst_i[31:25] == la32_id_pkg::OPC7_LU12I)
    begin
      op    = la32_id_pkg::ALU_LUI;
      imm_o = ui20_hi;
    end
    else if (valid_i)
    begin
      case (inst_i[31:26])
        la32_id_pkg::OPC6_JIRL:
        begin
          op    = la32_id_pkg::ALU_JIRL;
          imm_o = offs16_sext;
        end
        la32_id_pkg::OPC6_B:    op = la32_id_pkg::ALU_B;
        la32_id_pkg::OPC6_BL:   op = la32_id_pkg::ALU_BL;
        la32_id_pkg::OPC6_BEQ:  op = la32_id_pkg::ALU_BEQ;
        la32_id_pkg::OPC6_BNE:  op = la32_id_pkg::ALU_BNE;
        la32_id_pkg::OPC6_BLT:  op = la32_id_pkg::ALU_BLT;
        la32_id_pkg::OPC6_BGE:  op = la32_id_pkg::ALU_BGE;
        la32_id_pkg::OPC6_BLTU: op = la32_id_pkg::ALU_BLTU;
        la32_id_pkg::OPC6_BGEU: op = la32_id_pkg::ALU_BGEU;
        la32_id_pkg::OPC6_MEM:
        begin
          imm_o = si12_sext;
          casez (sub6)
            la32_id_pkg::OPC_SUB6_LD_B:  op = la32_id_pkg::ALU_LD_B;
            la32_id_pkg::OPC_SUB6_LD_H:  op = la32_id_pkg::ALU_LD_H;
            la32_id_pkg::OPC_SUB6_LD_W:  op = la32_id_pkg::ALU_LD_W;
            la32_id_pkg::OPC_SUB6_ST_B:  op = la32_id_pkg::ALU_ST_B;
            la32_id_pkg::OPC_SUB6_ST_H:  op = la32_id_pkg::ALU_ST_H;
            la32_id_pkg::OPC_SUB6_ST_W:  op = la32_id_pkg::ALU_ST_W;
            la32_id_pkg::OPC_SUB6_LD_BU: op = la32_id_pkg::ALU_LD_BU;
            la32_id_pkg::OPC_SUB6_LD_HU: op = la32_id_pkg::ALU_LD_HU;
            default:                     op = la32_id_pkg::ALU_NOP;
          endcase
        end
        la32_id_pkg::OPC6_ARITH:
        begin
          imm_o = si12_sext;
          casez (sub6)
            la32_id_pkg::OPC_SUB6_SLTI:  op = la32_id_pkg::ALU_SLT;
            la32_id_pkg::OPC_SUB6_SLTUI: op = la32_id_pkg::ALU_SLTU;
            la32_id_pkg::OPC_SUB6_ADDI:  op = la32_id_pkg::ALU_ADD;
            la32_id_pkg::OPC_SUB6_ANDI,
            la32_id_pkg::OPC_SUB6_ORI,
            la32_id_pkg::OPC_SUB6_XORI:
            begin
              // Logical immediates are zero extended
              imm_o = ui12_zext;
              case (sub6[3:2])
                2'b01:   op = la32_id_pkg::ALU_AND;
                2'b10:   op = la32_id_pkg::ALU_OR;
                default: op = la32_id_pkg::ALU_XOR;
              endcase
            end
            la32_id_pkg::OPC_SUB6_LONG:
            begin
              reg_reg = 1'b1;
              case (sub5)
                la32_id_pkg::OPC_SUB5_ADD:  op = la32_id_pkg::ALU_ADD;
                la32_id_pkg::OPC_SUB5_SUB:  op = la32_id_pkg::ALU_SUB;
                la32_id_pkg::OPC_SUB5_SLT:  op = la32_id_pkg::ALU_SLT;
                la32_id_pkg::OPC_SUB5_SLTU: op = la32_id_pkg::ALU_SLTU;
                la32_id_pkg::OPC_SUB5_NOR:  op = la32_id_pkg::ALU_NOR;
                la32_id_pkg::OPC_SUB5_AND:  op = la32_id_pkg::ALU_AND;
                la32_id_pkg::OPC_SUB5_OR:   op = la32_id_pkg::ALU_OR;
                la32_id_pkg::OPC_SUB5_XOR:  op = la32_id_pkg::ALU_XOR;
                la32_id_pkg::OPC_SUB5_SLL:  op = la32_id_pkg::ALU_SLL;
                la32_id_pkg::OPC_SUB5_SRL:  op = la32_id_pkg::ALU_SRL;
                la32_id_pkg::OPC_SUB5_SRA:  op = la32_id_pkg::ALU_SRA;
                default:                    op = la32_id_pkg::ALU_NOP;
              endcase
            end
            la32_id_pkg::OPC_SUB6_SHIFT:
            begin
              imm_o = ui5_zext;
              case (sub5)
                la32_id_pkg::OPC_SUB5_SLLI: op = la32_id_pkg::ALU_SLL;
                la32_id_pkg::OPC_SUB5_SRLI: op = la32_id_pkg::ALU_SRL;
                la32_id_pkg::OPC_SUB5_SRAI: op = la32_id_pkg::ALU_SRA;
                default:                    op = la32_id_pkg::ALU_NOP;
              endcase
            end
            default: op = la32_id_pkg::ALU_NOP;
          endcase
        end
        default: op = la32_id_pkg::ALU_NOP;
      endcase
      // Unknown sub-opcode leaves no immediate behind
      if (op == la32_id_pkg::ALU_NOP)
        imm_o = '0;
    end
  end

  // ALU op to register use, result class and branch kind
  always_comb
  begin
    inst_ok_o  = (op != la32_id_pkg::ALU_NOP);
    rd1_en_o   = inst_ok_o;
    rd2_en_o   = reg_reg && inst_ok_o;
    rd1_addr_o = rj;
    rd2_addr_o = rk;
    waddr_o    = rd;
    wreg_o     = inst_ok_o;
    alusel_o   = la32_id_pkg::SEL_NOP;
    br_kind_o  = la32_id_pkg::ALU_NOP;
    case (op)
      la32_id_pkg::ALU_ADD, la32_id_pkg::ALU_SUB, la32_id_pkg::ALU_SLT, la32_id_pkg::ALU_SLTU:
        alusel_o = la32_id_pkg::SEL_ARITH;
      la32_id_pkg::ALU_AND, la32_id_pkg::ALU_OR, la32_id_pkg::ALU_XOR, la32_id_pkg::ALU_NOR:
        alusel_o = la32_id_pkg::SEL_LOGIC;
      la32_id_pkg::ALU_SLL, la32_id_pkg::ALU_SRL, la32_id_pkg::ALU_SRA:
        alusel_o = la32_id_pkg::SEL_SHIFT;
      la32_id_pkg::ALU_LUI:
      begin
        alusel_o = la32_id_pkg::SEL_MOVE;
        rd1_en_o = 1'b0;
      end
      la32_id_pkg::ALU_LD_B, la32_id_pkg::ALU_LD_H, la32_id_pkg::ALU_LD_W,
      la32_id_pkg::ALU_LD_BU, la32_id_pkg::ALU_LD_HU:
        alusel_o = la32_id_pkg::SEL_LOAD_STORE;
      la32_id_pkg::ALU_ST_B, la32_id_pkg::ALU_ST_H, la32_id_pkg::ALU_ST_W:
      begin
        alusel_o = la32_id_pkg::SEL_LOAD_STORE;
        wreg_o   = 1'b0;
      end
      la32_id_pkg::ALU_JIRL:
      begin
        alusel_o  = la32_id_pkg::SEL_JUMP;
        br_kind_o = op;
      end
      la32_id_pkg::ALU_B, la32_id_pkg::ALU_BL:
      begin
        alusel_o  = la32_id_pkg::SEL_JUMP;
        br_kind_o = op;
        rd1_en_o  = 1'b0;
        wreg_o    = (op == la32_id_pkg::ALU_BL);
        waddr_o   = la32_id_pkg::LINK_REG;
      end
      la32_id_pkg::ALU_BEQ, la32_id_pkg::ALU_BNE, la32_id_pkg::ALU_BLT,
      la32_id_pkg::ALU_BGE, la32_id_pkg::ALU_BLTU, la32_id_pkg::ALU_BGEU:
      begin
        // Compare operands are rd then rj
        alusel_o   = la32_id_pkg::SEL_JUMP;
        br_kind_o  = op;
        rd2_en_o   = 1'b1;
        rd1_addr_o = rd;
        rd2_addr_o = rj;
        wreg_o     = 1'b0;
      end
      default:
        alusel_o = la32_id_pkg::SEL_NOP;
    endcase
  end

  assign aluop_o = op;

endmodule

// File: logic/la32_id_pkg.sv
package la32_id_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [WORD_W-1:0]     inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
    ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU, ALU_ST_B, ALU_ST_H, ALU_ST_W,
    ALU_JIRL, ALU_B, ALU_BL, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_t;

  typedef enum logic [2:0] {
    SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE, SEL_JUMP, SEL_LOAD_STORE
  } alu_sel_t;

  // Major opcode, bits 31:26
  localparam logic [5:0] OPC6_JIRL  = 6'b010011;
  localparam logic [5:0] OPC6_B     = 6'b010100;
  localparam logic [5:0] OPC6_BL    = 6'b010101;
  localparam logic [5:0] OPC6_BEQ   = 6'b010110;
  localparam logic [5:0] OPC6_BNE   = 6'b010111;
  localparam logic [5:0] OPC6_BLT   = 6'b011000;
  localparam logic [5:0] OPC6_BGE   = 6'b011001;
  localparam logic [5:0] OPC6_BLTU  = 6'b011010;
  localparam logic [5:0] OPC6_BGEU  = 6'b011011;
  localparam logic [5:0] OPC6_MEM   = 6'b001010;
  localparam logic [5:0] OPC6_ARITH = 6'b000000;

  localparam logic [6:0] OPC7_LU12I = 7'b0001010;

  // Bits 25:20 whose low two bits belong to si12/ui12 in the immediate forms
  localparam logic [5:0] OPC_SUB6_LD_B  = 6'b0000??;
  localparam logic [5:0] OPC_SUB6_LD_H  = 6'b0001??;
  localparam logic [5:0] OPC_SUB6_LD_W  = 6'b0010??;
  localparam logic [5:0] OPC_SUB6_ST_B  = 6'b0100??;
  localparam logic [5:0] OPC_SUB6_ST_H  = 6'b0101??;
  localparam logic [5:0] OPC_SUB6_ST_W  = 6'b0110??;
  localparam logic [5:0] OPC_SUB6_LD_BU = 6'b1000??;
  localparam logic [5:0] OPC_SUB6_LD_HU = 6'b1001??;
  localparam logic [5:0] OPC_SUB6_SLTI  = 6'b1000??;
  localparam logic [5:0] OPC_SUB6_SLTUI = 6'b1001??;
  localparam logic [5:0] OPC_SUB6_ADDI  = 6'b1010??;
  localparam logic [5:0] OPC_SUB6_ANDI  = 6'b1101??;
  localparam logic [5:0] OPC_SUB6_ORI   = 6'b1110??;
  localparam logic [5:0] OPC_SUB6_XORI  = 6'b1111??;
  localparam logic [5:0] OPC_SUB6_LONG  = 6'b000001;
  localparam logic [5:0] OPC_SUB6_SHIFT = 6'b000100;

  // Bits 19:15 inside LONG and SHIFT
  localparam logic [4:0] OPC_SUB5_ADD  = 5'b00000;
  localparam logic [4:0] OPC_SUB5_SUB  = 5'b00010;
  localparam logic [4:0] OPC_SUB5_SLT  = 5'b00100;
  localparam logic [4:0] OPC_SUB5_SLTU = 5'b00101;
  localparam logic [4:0] OPC_SUB5_NOR  = 5'b01000;
  localparam logic [4:0] OPC_SUB5_AND  = 5'b01001;
  localparam logic [4:0] OPC_SUB5_OR   = 5'b01010;
  localparam logic [4:0] OPC_SUB5_XOR  = 5'b01011;
  localparam logic [4:0] OPC_SUB5_SLL  = 5'b01110;
  localparam logic [4:0] OPC_SUB5_SRL  = 5'b01111;
  localparam logic [4:0] OPC_SUB5_SRA  = 5'b10000;
  localparam logic [4:0] OPC_SUB5_SLLI = 5'b00001;
  localparam logic [4:0] OPC_SUB5_SRLI = 5'b01001;
  localparam logic [4:0] OPC_SUB5_SRAI = 5'b10001;

  localparam reg_addr_t ZERO_REG   = 5'd0;
  localparam reg_addr_t LINK_REG   = 5'd1;
  localparam word_t     INST_BYTES = 32'd4;

endpackage

// File: logic/operand_forward.sv
module operand_forward (
  input  logic                   rd_en_i,
  input  la32_id_pkg::reg_addr_t rd_addr_i,
  input  la32_id_pkg::word_t     rf_data_i,
  input  la32_id_pkg::word_t     imm_i,
  input  logic                   ex_wreg_i,
  input  la32_id_pkg::reg_addr_t ex_waddr_i,
  input  la32_id_pkg::word_t     ex_wdata_i,
  input  logic                   mem_wreg_i,
  input  la32_id_pkg::reg_addr_t mem_waddr_i,
  input  la32_id_pkg::word_t     mem_wdata_i,
  output la32_id_pkg::word_t     operand_o
);

  // Youngest producer wins
  always_comb
  begin
    if (!rd_en_i)
      operand_o = imm_i;
    else if (rd_addr_i == la32_id_pkg::ZERO_REG)
      operand_o = '0;
    else if (ex_wreg_i && ex_waddr_i == rd_addr_i)
      operand_o = ex_wdata_i;
    else if (mem_wreg_i && mem_waddr_i == rd_addr_i)
      operand_o = mem_wdata_i;
    else
      operand_o = rf_data_i;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module id_stage_tb -f id_stage.f \
  -o sim_id_stage > build.log 2>&1 \
  && ./obj_dir/sim_id_stage > sim.log 2>&1
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL (see build.log and sim.log)"; exit 1; }

// File: testbench/id_stage_sva.sv
module id_stage_sva (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   id_valid_i,
  input logic                   stall_i,
  input logic                   branch_flag_o,
  input logic                   ex_valid_o,
  input la32_id_pkg::alu_op_t   ex_aluop_o,
  input la32_id_pkg::alu_sel_t  ex_alusel_o,
  input la32_id_pkg::word_t     ex_reg1_o,
  input la32_id_pkg::word_t     ex_reg2_o,
  input la32_id_pkg::reg_addr_t ex_waddr_o,
  input logic                   ex_wreg_o,
  input la32_id_pkg::word_t     ex_link_addr_o
);

  // A write to the register file only comes with a valid bundle
  wreg_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    ex_wreg_o |-> ex_valid_o)
    else $error("ex_wreg_o high while ex_valid_o is low");

  no_branch_when_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    !id_valid_i |-> !branch_flag_o)
    else $error("branch taken without a valid instruction");

  // Stall at one edge keeps the bundle until the next
  stall_holds_bundle: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i |=> ($stable(ex_valid_o) && $stable(ex_aluop_o) && $stable(ex_alusel_o)
                 && $stable(ex_reg1_o) && $stable(ex_reg2_o) && $stable(ex_waddr_o)
                 && $stable(ex_wreg_o) && $stable(ex_link_addr_o)))
    else $error("bundle changed during a stall");

endmodule

// File: testbench/id_stage_tb.sv
module id_stage_tb;

  localparam int MAX_VEC = 64;
  localparam int NFIELD  = 27;

  logic                   clk;
  logic                   rst_n_i;
  logic                   id_valid_i;
  logic                   stall_i;
  la32_id_pkg::word_t     pc_i;
  la32_id_pkg::inst_t     inst_i;
  la32_id_pkg::word_t     reg1_data_i;
  la32_id_pkg::word_t     reg2_data_i;
  logic                   ex_wreg_i;
  la32_id_pkg::reg_addr_t ex_waddr_i;
  la32_id_pkg::word_t     ex_wdata_i;
  logic                   mem_wreg_i;
  la32_id_pkg::reg_addr_t mem_waddr_i;
  la32_id_pkg::word_t     mem_wdata_i;
  logic                   reg1_read_o;
  la32_id_pkg::reg_addr_t reg1_addr_o;
  logic                   reg2_read_o;
  la32_id_pkg::reg_addr_t reg2_addr_o;
  logic                   branch_flag_o;
  la32_id_pkg::word_t     branch_target_o;
  la32_id_pkg::word_t     link_addr_o;
  logic                   ex_valid_o;
  la32_id_pkg::alu_op_t   ex_aluop_o;
  la32_id_pkg::alu_sel_t  ex_alusel_o;
  la32_id_pkg::word_t     ex_reg1_o;
  la32_id_pkg::word_t     ex_reg2_o;
  la32_id_pkg::reg_addr_t ex_waddr_o;
  logic                   ex_wreg_o;
  la32_id_pkg::word_t     ex_link_addr_o;

  logic [31:0] vecs [0:MAX_VEC-1][0:NFIELD-1];
  int          nvec;
  int          errors;
  int          cycles;
  int          cycle_limit;

  tb_clock_gen #(.PERIOD(8)) u_clock_gen (
    .clk_o (clk)
  );

  id_stage u_id_stage (.*);

  bind id_stage id_stage_sva u_sva (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .id_valid_i     (id_valid_i),
    .stall_i        (stall_i),
    .branch_flag_o  (branch_flag_o),
    .ex_valid_o     (ex_valid_o),
    .ex_aluop_o     (ex_aluop_o),
    .ex_alusel_o    (ex_alusel_o),
    .ex_reg1_o      (ex_reg1_o),
    .ex_reg2_o      (ex_reg2_o),
    .ex_waddr_o     (ex_waddr_o),
    .ex_wreg_o      (ex_wreg_o),
    .ex_link_addr_o (ex_link_addr_o)
  );

  task automatic check_word(input la32_id_pkg::word_t got, input la32_id_pkg::word_t exp,
                            input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input la32_id_pkg::reg_addr_t got,
                            input la32_id_pkg::reg_addr_t exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input la32_id_pkg::alu_op_t got, input la32_id_pkg::alu_op_t exp,
                          input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_sel(input la32_id_pkg::alu_sel_t got,
                           input la32_id_pkg::alu_sel_t exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  // Lines starting with # are skipped
  task automatic load_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [0:NFIELD-1];
    fd   = $fopen("testbench/id_stage_testdata.txt", "r");
    nvec = 0;
    if (fd == 0)
    begin
      $display("Could not open the test data file");
      return;
    end
    while ($fgets(line, fd) != 0 && nvec < MAX_VEC)
    begin
      if (line.len() > 0 && line[0] != "#")
      begin
        cnt = $sscanf(line,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
          f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23], f[24],
          f[25], f[26]);
        if (cnt == NFIELD)
        begin
          for (int k = 0; k < NFIELD; k++)
            vecs[nvec][k] = f[k];
          nvec++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_vector(input int i);
    stall_i     = vecs[i][0][0];
    id_valid_i  = vecs[i][1][0];
    pc_i        = vecs[i][2];
    inst_i      = vecs[i][3];
    reg1_data_i = vecs[i][4];
    reg2_data_i = vecs[i][5];
    ex_wreg_i   = vecs[i][6][0];
    ex_waddr_i  = vecs[i][7][4:0];
    ex_wdata_i  = vecs[i][8];
    mem_wreg_i  = vecs[i][9][0];
    mem_waddr_i = vecs[i][10][4:0];
    mem_wdata_i = vecs[i][11];
  endtask

  task automatic check_comb(input int i);
    check_bit(reg1_read_o, vecs[i][12][0], "reg1_read_o");
    check_addr(reg1_addr_o, vecs[i][13][4:0], "reg1_addr_o");
    check_bit(reg2_read_o, vecs[i][14][0], "reg2_read_o");
    check_addr(reg2_addr_o, vecs[i][15][4:0], "reg2_addr_o");
    check_bit(branch_flag_o, vecs[i][16][0], "branch_flag_o");
    check_word(branch_target_o, vecs[i][17], "branch_target_o");
    check_word(link_addr_o, vecs[i][18], "link_addr_o");
  endtask

  task automatic check_bundle(input int i);
    check_bit(ex_valid_o, vecs[i][19][0], "ex_valid_o");
    check_op(ex_aluop_o, la32_id_pkg::alu_op_t'(vecs[i][20][4:0]), "ex_aluop_o");
    check_sel(ex_alusel_o, la32_id_pkg::alu_sel_t'(vecs[i][21][2:0]), "ex_alusel_o");
    check_word(ex_reg1_o, vecs[i][22], "ex_reg1_o");
    check_word(ex_reg2_o, vecs[i][23], "ex_reg2_o");
    check_addr(ex_waddr_o, vecs[i][24][4:0], "ex_waddr_o");
    check_bit(ex_wreg_o, vecs[i][25][0], "ex_wreg_o");
    check_word(ex_link_addr_o, vecs[i][26], "ex_link_addr_o");
  endtask

  // Run limit from the vector count
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the test did not finish", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial
  begin
    rst_n_i     = 1'b0;
    id_valid_i  = 1'b0;
    stall_i     = 1'b0;
    pc_i        = '0;
    inst_i      = '0;
    reg1_data_i = '0;
    reg2_data_i = '0;
    ex_wreg_i   = 1'b0;
    ex_waddr_i  = '0;
    ex_wdata_i  = '0;
    mem_wreg_i  = 1'b0;
    mem_waddr_i = '0;
    mem_wdata_i = '0;
    errors      = 0;
    cycles      = 0;
    load_vectors();
    if (nvec == 0)
    begin
      errors++;
      $display("No test vectors were read");
    end
    cycle_limit = nvec * 2 + 5 + 20;

    repeat (5) @(negedge clk);
    check_bit(ex_valid_o, 1'b0, "ex_valid_o after reset");
    check_bit(ex_wreg_o, 1'b0, "ex_wreg_o after reset");
    check_op(ex_aluop_o, la32_id_pkg::ALU_NOP, "ex_aluop_o after reset");
    rst_n_i = 1'b1;

    for (int i = 0; i < nvec; i++)
    begin
      @(negedge clk);
      if (i > 0)
        check_bundle(i - 1);
      drive_vector(i);
      #3;
      check_comb(i);
    end
    @(negedge clk);
    if (nvec > 0)
      check_bundle(nvec - 1);

    $display("Finished with %0d errors", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: testbench/id_stage_testdata.txt
# stall valid pc inst rf1 rf2 exw exa exd memw mema memd | rd1en rd1a rd2en rd2a br tgt link
# | xvalid xop xsel xreg1 xreg2 xwaddr xwreg xlink (all hex)
0 1 00000100 00101483 11111111 22222222 0 00 00000000 0 00 00000000 1 04 1 05 0 00000000 00000000 1 01 3 11111111 22222222 03 1 00000000
1 1 00000104 001120E6 33333333 44444444 0 00 00000000 0 00 00000000 1 07 1 08 0 00000000 00000000 1 01 3 11111111 22222222 03 1 00000000
0 1 00000104 001120E6 33333333 00000008 1 07 AAAA0000 1 07 BBBB0000 1 07 1 08 0 00000000 00000000 1 02 3 AAAA0000 00000008 06 1 00000000
0 1 00000108 00142809 DEADBEEF 12345678 1 00 00000001 1 0A 5A5A5A5A 1 00 1 0A 0 00000000 00000000 1 08 1 00000000 5A5A5A5A 09 1 00000000
0 1 0000010C 001839AC 80000000 00000004 0 00 00000000 0 00 00000000 1 0D 1 0E 0 00000000 00000000 1 0B 2 80000000 00000004 0C 1 00000000
0 1 00000110 00489E0F F0000000 99999999 0 00 00000000 0 00 00000000 1 10 0 07 0 00000000 00000000 1 0B 2 F0000000 00000007 0F 1 00000000
0 1 00000114 02BFFE51 00000010 00000000 0 00 00000000 0 00 00000000 1 12 0 1F 0 00000000 00000000 1 01 3 00000010 FFFFFFFF 11 1 00000000
0 1 00000118 03600293 FFFF0000 00000000 0 00 00000000 0 00 00000000 1 14 0 00 0 00000000 00000000 1 05 1 FFFF0000 00000800 13 1 00000000
0 1 0000011C 026002D5 00000123 00000000 0 00 00000000 0 00 00000000 1 16 0 00 0 00000000 00000000 1 04 3 00000123 FFFFF800 15 1 00000000
0 1 00001000 600010A4 FFFFFFFF 00000001 0 00 00000000 0 00 00000000 1 04 1 05 1 00001010 00000000 1 1A 5 FFFFFFFF 00000001 04 0 00000000
0 1 00001004 680010A4 FFFFFFFF 00000001 0 00 00000000 0 00 00000000 1 04 1 05 0 00000000 00000000 1 1C 5 FFFFFFFF 00000001 04 0 00000000
0 1 00002000 67FFF8A4 00000001 80000000 0 00 00000000 0 00 00000000 1 04 1 05 1 00001FF8 00000000 1 1B 5 00000001 80000000 04 0 00000000
0 1 00003000 6C0010A4 80000000 00000001 0 00 00000000 0 00 00000000 1 04 1 05 1 00003010 00000000 1 1D 5 80000000 00000001 04 0 00000000
0 1 00004000 580010A4 00000005 00000006 0 00 00000000 1 05 00000005 1 04 1 05 1 00004010 00000000 1 18 5 00000005 00000005 04 0 00000000
0 1 00004100 5C0010A4 00000007 00000007 0 00 00000000 0 00 00000000 1 04 1 05 0 00000000 00000000 1 19 5 00000007 00000007 04 0 00000000
0 1 00005000 50040000 00000000 00000000 0 00 00000000 0 00 00000000 0 00 0 00 1 00005400 00000000 1 16 5 00000000 00000000 01 0 00000000
0 1 00006000 57FFF3FF 00000000 00000000 0 00 00000000 0 00 00000000 0 1F 0 1C 1 00005FF0 00006004 1 17 5 00000000 00000000 01 1 00006004
0 1 00007000 4C0020C2 00000000 00000000 1 06 00010000 0 00 00000000 1 06 0 08 1 00010020 00007004 1 15 5 00010000 00000020 02 1 00007004
0 1 00007004 15000027 00000000 00000000 0 00 00000000 0 00 00000000 0 01 0 00 0 00000000 00000000 1 0C 4 80001000 80001000 07 1 00000000
0 1 00007008 28BFF128 00001000 00000000 0 00 00000000 0 00 00000000 1 09 0 1C 0 00000000 00000000 1 0F 6 00001000 FFFFFFFC 08 1 00000000
0 1 0000700C 2940416A 00002000 00000000 0 00 00000000 0 00 00000000 1 0B 0 10 0 00000000 00000000 1 13 6 00002000 00000010 0A 0 00000000
0 1 00007010 2A0005AC 00003000 00000000 0 00 00000000 0 00 00000000 1 0D 0 01 0 00000000 00000000 1 10 6 00003000 00000001 0C 1 00000000
0 1 00007014 FC000000 00000000 00000000 0 00 00000000 0 00 00000000 0 00 0 00 0 00000000 00000000 0 00 0 00000000 00000000 00 0 00000000
0 0 00007018 580010A4 00000005 00000005 0 00 00000000 0 00 00000000 0 05 0 04 0 00000000 00000000 0 00 0 00000000 00000000 04 0 00000000
1 1 0000701C 00101483 11111111 22222222 0 00 00000000 0 00 00000000 1 04 1 05 0 00000000 00000000 0 00 0 00000000 00000000 04 0 00000000

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule
